// File: Bender.yml
package:
  name: cacheline_adapter

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/line_adapter_pkg.sv
      - source/dfp_request_latch.sv
      - source/burst_sequencer.sv
      - source/deserializer.sv
      - source/cacheline_adapter.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/tb_burst_memory.sv
      - testbench/tb_cacheline_adapter.sv

// File: source/burst_sequencer.sv
`timescale 1ns/1ns

`include "line_adapter_config.svh"

module burst_sequencer (
    input  logic                          clk,
    input  logic                          rst,

    // latched request
    input  logic                          req_valid,
    input  logic                          req_is_write,
    input  line_adapter_pkg::addr_t       req_line_addr,

    // memory flow control
    input  logic                          bmem_ready,

    // read line complete, from the deserializer
    input  logic                          line_filled,

    // memory command side
    output line_adapter_pkg::addr_t       bmem_addr,
    output logic                          bmem_read,
    output logic                          bmem_write,

    // to the deserializer
    output line_adapter_pkg::beat_idx_t   write_beat_idx,
    output logic                          read_pending,

    // response pulse, to the cache and to the latch
    output logic                          dfp_resp,
    output logic                          resp_done
);
    import line_adapter_pkg::*;

    localparam beat_idx_t LAST_BEAT = beat_idx_t'(`BEATS_PER_LINE - 1);

    seq_state_t state_q;
    seq_state_t state_d;
    beat_idx_t  beat_cnt;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            SEQ_IDLE: begin
                if (req_valid) begin
                    state_d = req_is_write ? SEQ_WRITE_BEATS : SEQ_READ_CMD;
                end
            end
            SEQ_READ_CMD: begin
                // command accepted on ready
                if (bmem_ready) begin
                    state_d = SEQ_READ_WAIT;
                end
            end
            SEQ_READ_WAIT: begin
                if (line_filled) begin
                    state_d = SEQ_RESP;
                end
            end
            SEQ_WRITE_BEATS: begin
                // last beat taken
                if (bmem_ready && beat_cnt == LAST_BEAT) begin
                    state_d = SEQ_RESP;
                end
            end
            SEQ_RESP: state_d = SEQ_IDLE;
            default:  state_d = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= SEQ_IDLE;
            beat_cnt <= '0;
        end else begin
            state_q <= state_d;
            // count accepted write beats only
            if (state_q == SEQ_WRITE_BEATS && bmem_ready) begin
                beat_cnt <= (beat_cnt == LAST_BEAT) ? '0 : beat_cnt + 1'b1;
            end
        end
    end

    // memory pins decoded from state
    assign bmem_read  = (state_q == SEQ_READ_CMD);
    assign bmem_write = (state_q == SEQ_WRITE_BEATS);
    // line base while a command or beat is out
    assign bmem_addr  = (bmem_read || bmem_write) ? req_line_addr : '0;

    assign write_beat_idx = beat_cnt;
    // accepted read still waiting for its line
    assign read_pending   = (state_q == SEQ_READ_WAIT);

    assign dfp_resp  = (state_q == SEQ_RESP);
    assign resp_done = (state_q == SEQ_RESP);

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        !(bmem_read && bmem_write))
        else $error("bmem_read and bmem_write both high");

    a_write_in_state: assert property (@(posedge clk) disable iff (rst)
        bmem_write |-> state_q == SEQ_WRITE_BEATS)
        else $error("bmem_write outside write beats");

endmodule

// File: source/cacheline_adapter.sv
`timescale 1ns/1ns

`include "line_adapter_config.svh"

module cacheline_adapter (
    input  logic                      clk,
    input  logic                      rst,

    // cache side
    input  line_adapter_pkg::addr_t   dfp_addr,
    input  logic                      dfp_read,
    input  logic                      dfp_write,
    input  line_adapter_pkg::line_t   dfp_wdata,
    output line_adapter_pkg::line_t   dfp_rdata,
    output logic                      dfp_resp,

    // burst memory side
    input  logic                      bmem_ready,
    input  line_adapter_pkg::addr_t   bmem_raddr,
    input  line_adapter_pkg::beat_t   bmem_rdata,
    input  logic                      bmem_rvalid,
    output line_adapter_pkg::addr_t   bmem_addr,
    output logic                      bmem_read,
    output logic                      bmem_write,
    output line_adapter_pkg::beat_t   bmem_wdata
);
    import line_adapter_pkg::*;

    // latch to sequencer
    logic      req_valid;
    logic      req_is_write;
    addr_t     req_line_addr;
    line_t     req_wdata;
    logic      resp_done;

    // sequencer and deserializer handoff
    beat_idx_t write_beat_idx;
    logic      read_pending;
    logic      line_filled;

    dfp_request_latch latch0 (
        .clk           (clk),
        .rst           (rst),
        .dfp_addr      (dfp_addr),
        .dfp_read      (dfp_read),
        .dfp_write     (dfp_write),
        .dfp_wdata     (dfp_wdata),
        .resp_done     (resp_done),
        .req_valid     (req_valid),
        .req_is_write  (req_is_write),
        .req_line_addr (req_line_addr),
        .req_wdata     (req_wdata)
    );

    burst_sequencer seq0 (
        .clk            (clk),
        .rst            (rst),
        .req_valid      (req_valid),
        .req_is_write   (req_is_write),
        .req_line_addr  (req_line_addr),
        .bmem_ready     (bmem_ready),
        .line_filled    (line_filled),
        .bmem_addr      (bmem_addr),
        .bmem_read      (bmem_read),
        .bmem_write     (bmem_write),
        .write_beat_idx (write_beat_idx),
        .read_pending   (read_pending),
        .dfp_resp       (dfp_resp),
        .resp_done      (resp_done)
    );

    deserializer deser0 (
        .clk            (clk),
        .rst            (rst),
        .req_line_addr  (req_line_addr),
        .req_wdata      (req_wdata),
        .write_beat_idx (write_beat_idx),
        .bmem_write     (bmem_write),
        .read_pending   (read_pending),
        .bmem_raddr     (bmem_raddr),
        .bmem_rdata     (bmem_rdata),
        .bmem_rvalid    (bmem_rvalid),
        .bmem_wdata     (bmem_wdata),
        .dfp_rdata      (dfp_rdata),
        .line_filled    (line_filled)
    );

endmodule

// File: source/deserializer.sv
`timescale 1ns/1ns

`include "line_adapter_config.svh"

module deserializer (
    input  logic                          clk,
    input  logic                          rst,

    // held request
    input  line_adapter_pkg::addr_t       req_line_addr,
    input  line_adapter_pkg::line_t       req_wdata,

    // write beat select from the sequencer
    input  line_adapter_pkg::beat_idx_t   write_beat_idx,
    input  logic                          bmem_write,

    // read window from the sequencer
    input  logic                          read_pending,

    // memory read beats
    input  line_adapter_pkg::addr_t       bmem_raddr,
    input  line_adapter_pkg::beat_t       bmem_rdata,
    input  logic                          bmem_rvalid,

    output line_adapter_pkg::beat_t       bmem_wdata,
    output line_adapter_pkg::line_t       dfp_rdata,
    output logic                          line_filled
);
    import line_adapter_pkg::*;

    localparam beat_idx_t LAST_BEAT = beat_idx_t'(`BEATS_PER_LINE - 1);

    beat_idx_t rd_cnt;
    line_t     acc;
    line_t     acc_next;
    logic      take;

    // write direction, one beat of the held line
    always_comb begin
        bmem_wdata = '0;
        if (bmem_write) begin
            bmem_wdata = req_wdata[int'(write_beat_idx) * `BEAT_BITS +: `BEAT_BITS];
        end
    end

    // first beat must carry the current line tag
    // the rest follow in order
    assign take = bmem_rvalid && read_pending &&
                  (rd_cnt != '0 || bmem_raddr == req_line_addr);

    // accumulator with the incoming beat dropped in place
    always_comb begin
        acc_next = acc;
        acc_next[int'(rd_cnt) * `BEAT_BITS +: `BEAT_BITS] = bmem_rdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_cnt      <= '0;
            line_filled <= 1'b0;
        end else begin
            line_filled <= 1'b0;
            if (take) begin
                if (rd_cnt == LAST_BEAT) begin
                    rd_cnt      <= '0;
                    line_filled <= 1'b1;
                end else begin
                    rd_cnt <= rd_cnt + 1'b1;
                end
            end
        end
    end

    // line data, published only on the last beat
    always_ff @(posedge clk) begin
        if (take) begin
            acc <= acc_next;
            if (rd_cnt == LAST_BEAT) begin
                dfp_rdata <= acc_next;
            end
        end
    end

    // beats outside the read window leave the counter alone
    a_no_take_idle: assert property (@(posedge clk) disable iff (rst)
        bmem_rvalid && !read_pending |=> rd_cnt == $past(rd_cnt))
        else $error("rvalid beat taken with no read pending");

    // sequencer must still be waiting when the line completes
    a_fill_in_window: assert property (@(posedge clk) disable iff (rst)
        line_filled |-> read_pending)
        else $error("line_filled outside the read window");

endmodule

// File: source/dfp_request_latch.sv
`timescale 1ns/1ns

`include "line_adapter_config.svh"

module dfp_request_latch (
    input  logic                     clk,
    input  logic                     rst,

    // cache side request, held as levels
    input  line_adapter_pkg::addr_t  dfp_addr,
    input  logic                     dfp_read,
    input  logic                     dfp_write,
    input  line_adapter_pkg::line_t  dfp_wdata,

    // end of request from the sequencer
    input  logic                     resp_done,

    // latched request
    output logic                     req_valid,
    output logic                     req_is_write,
    output line_adapter_pkg::addr_t  req_line_addr,
    output line_adapter_pkg::line_t  req_wdata
);
    import line_adapter_pkg::*;

    // byte offset bits inside one line
    localparam int OFFSET_BITS = $clog2(`LINE_BITS / 8);

    // one cycle block after a response
    logic cooldown;
    logic capture;

    // take a new request only when idle and out of cooldown
    assign capture = !req_valid && !cooldown && (dfp_read || dfp_write);

    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid    <= 1'b0;
            req_is_write <= 1'b0;
            cooldown     <= 1'b0;
        end else begin
            cooldown <= 1'b0;
            if (req_valid) begin
                // hold until the sequencer answers
                if (resp_done) begin
                    req_valid <= 1'b0;
                    cooldown  <= 1'b1;
                end
            end else if (capture) begin
                req_valid    <= 1'b1;
                req_is_write <= dfp_write;
            end
        end
    end

    // address and write line, loaded on capture only
    always_ff @(posedge clk) begin
        if (capture) begin
            // align to the line base
            req_line_addr <= {dfp_addr[`ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
            req_wdata     <= dfp_wdata;
        end
    end

    // cache must never ask for both directions at once
    a_one_direction: assert property (@(posedge clk) disable iff (rst)
        !(dfp_read && dfp_write))
        else $error("dfp_read and dfp_write both high");

    // response from the sequencer only while a request is held
    a_resp_needs_req: assert property (@(posedge clk) disable iff (rst)
        resp_done |-> req_valid)
        else $error("resp_done without a held request");

endmodule

// File: source/line_adapter_config.svh
`ifndef LINE_ADAPTER_CONFIG_SVH
`define LINE_ADAPTER_CONFIG_SVH

// width of one cache line as the dfp side sees it
`define LINE_BITS 256

// width of one burst beat on the bmem side
`define BEAT_BITS 64

// beats per line, fixed by the burst memory
`define BEATS_PER_LINE 4

// byte address width on both sides
`define ADDR_BITS 32

// line size works out to 32 bytes
// so the low five address bits are the offset inside a line
// dfp_addr offset bits are dropped in the request latch
// bmem_addr and bmem_raddr always carry the aligned base

`endif

// File: source/line_adapter_pkg.sv
package line_adapter_pkg;

    `include "line_adapter_config.svh"

    // byte address, dfp and bmem share the same width
    typedef logic [`ADDR_BITS-1:0] addr_t;

    // one full cache line
    typedef logic [`LINE_BITS-1:0] line_t;

    // one memory beat
    typedef logic [`BEAT_BITS-1:0] beat_t;

    // beat position inside a line
    // beat 0 sits in the lowest bits of the line
    typedef logic [$clog2(`BEATS_PER_LINE)-1:0] beat_idx_t;

    // burst sequencer states
    // idle waits for a latched request
    // read_cmd holds bmem_read until bmem_ready
    // read_wait waits for the deserializer to fill the line
    // write_beats pushes one beat per ready cycle
    // resp is the single cycle of dfp_resp
    typedef enum logic [2:0] {
        SEQ_IDLE        = 3'd0,
        SEQ_READ_CMD    = 3'd1,
        SEQ_READ_WAIT   = 3'd2,
        SEQ_WRITE_BEATS = 3'd3,
        SEQ_RESP        = 3'd4
    } seq_state_t;

    // read path
    //   idle -> read_cmd -> read_wait -> resp -> idle
    // write path
    //   idle -> write_beats -> resp -> idle
    // a low bmem_ready freezes read_cmd and write_beats

endpackage

// File: testbench/tb_burst_memory.sv
`timescale 1ns/1ns

`include "line_adapter_config.svh"

module tb_burst_memory (
    input  logic                     clk,
    input  logic                     rst,
    // per-row controls from the testbench top
    input  logic                     stall_en,
    input  logic                     stale_en,
    input  line_adapter_pkg::addr_t  bmem_addr,
    input  logic                     bmem_read,
    input  logic                     bmem_write,
    input  line_adapter_pkg::beat_t  bmem_wdata,
    output logic                     bmem_ready,
    output line_adapter_pkg::addr_t  bmem_raddr,
    output line_adapter_pkg::beat_t  bmem_rdata,
    output logic                     bmem_rvalid
);
    import line_adapter_pkg::*;

    localparam int BEAT_BYTES = `BEAT_BITS / 8;

    // beat storage keyed by beat byte address
    beat_t store [addr_t];
    // accepted write beats, inspected by the testbench top
    addr_t wr_log_addr [0:255];
    beat_t wr_log_data [0:255];
    int    wr_log_n;
    int    rd_cmd_n;
    addr_t rd_cmd_addr;
    int    hold_errs;

    logic [15:0] lfsr;
    int          wcnt;
    logic        rd_active;
    int          rd_step;
    addr_t       rd_base;
    logic        held_valid;
    beat_t       held_data;

    // galois lfsr, one step per bit taken
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // unwritten beat, address above its inverse
    function automatic beat_t pattern_beat(input addr_t a);
        return {a, ~a};
    endfunction

    function automatic beat_t fetch_beat(input addr_t a);
        return store.exists(a) ? store[a] : pattern_beat(a);
    endfunction

    // everything moves on the falling edge, dut samples on the rising one
    initial begin
        bmem_ready  = 1'b1;
        bmem_rvalid = 1'b0;
        bmem_raddr  = '0;
        bmem_rdata  = '0;
        wr_log_n    = 0;
        rd_cmd_n    = 0;
        rd_cmd_addr = '0;
        hold_errs   = 0;
        lfsr        = 16'd12;
        wcnt        = 0;
        rd_active   = 1'b0;
        rd_step     = 0;
        rd_base     = '0;
        held_valid  = 1'b0;
        held_data   = '0;
        forever begin
            @(negedge clk);
            if (rst) begin
                bmem_ready  = 1'b1;
                bmem_rvalid = 1'b0;
                rd_active   = 1'b0;
                wcnt        = 0;
                held_valid  = 1'b0;
            end else begin
                // beat stalled last cycle must still be on the pins
                if (held_valid && (!bmem_write || bmem_wdata !== held_data)) begin
                    hold_errs++;
                    $display("MISMATCH @%0t stalled write beat changed, %h now %h",
                             $time, held_data, bmem_wdata);
                end
                if (stall_en) begin
                    bmem_ready = lfsr[0];
                    lfsr       = lfsr_step(lfsr);
                end else begin
                    bmem_ready = 1'b1;
                end
                held_valid = bmem_write && !bmem_ready;
                held_data  = bmem_wdata;
                // write beat taken at the coming edge
                if (bmem_write && bmem_ready) begin
                    wr_log_addr[wr_log_n] = bmem_addr;
                    wr_log_data[wr_log_n] = bmem_wdata;
                    wr_log_n++;
                    store[bmem_addr + addr_t'(wcnt * BEAT_BYTES)] = bmem_wdata;
                    wcnt = (wcnt + 1) % `BEATS_PER_LINE;
                end
                // read answer, stale beat at step 1, real beats from step 3
                bmem_rvalid = 1'b0;
                if (rd_active) begin
                    rd_step++;
                    if (rd_step == 1 && stale_en) begin
                        bmem_rvalid = 1'b1;
                        bmem_raddr  = rd_base + addr_t'(64);
                        bmem_rdata  = pattern_beat(rd_base + addr_t'(64));
                    end else if (rd_step >= 3) begin
                        bmem_rvalid = 1'b1;
                        bmem_raddr  = rd_base;
                        bmem_rdata  = fetch_beat(rd_base + addr_t'((rd_step - 3) * BEAT_BYTES));
                        rd_active   = (rd_step < 3 + `BEATS_PER_LINE - 1);
                    end
                end
                // read command taken at the coming edge
                if (bmem_read && bmem_ready) begin
                    rd_cmd_n++;
                    rd_cmd_addr = bmem_addr;
                    rd_base     = bmem_addr;
                    rd_active   = 1'b1;
                    rd_step     = 0;
                end
            end
        end
    end

endmodule

// File: testbench/tb_cacheline_adapter.sv
`timescale 1ns/1ns

`include "line_adapter_config.svh"

module tb_cacheline_adapter;
    import line_adapter_pkg::*;

    localparam int ROWS = 12;

    localparam line_t WDATA_A = {
        64'h0123_4567_89ab_cdef, 64'hfedc_ba98_7654_3210,
        64'h1111_2222_3333_4444, 64'h5555_6666_7777_8888
    };
    localparam line_t WDATA_B = {
        64'hdead_beef_0000_0001, 64'hcafe_f00d_0000_0002,
        64'h0bad_c0de_0000_0003, 64'h600d_d00d_0000_0004
    };
    localparam line_t WDATA_C = {
        64'ha5a5_a5a5_5a5a_5a5a, 64'h0f0f_0f0f_f0f0_f0f0,
        64'h3c3c_3c3c_c3c3_c3c3, 64'h9696_9696_6969_6969
    };

    logic  clk;
    logic  rst;
    addr_t dfp_addr;
    logic  dfp_read;
    logic  dfp_write;
    line_t dfp_wdata;
    line_t dfp_rdata;
    logic  dfp_resp;
    logic  bmem_ready;
    addr_t bmem_raddr;
    beat_t bmem_rdata;
    logic  bmem_rvalid;
    addr_t bmem_addr;
    logic  bmem_read;
    logic  bmem_write;
    beat_t bmem_wdata;
    logic  stall_en;
    logic  stale_en;

    // stimulus table, one entry per request
    logic  tbl_is_write [ROWS];
    addr_t tbl_addr     [ROWS];
    line_t tbl_wdata    [ROWS];
    logic  tbl_stall    [ROWS];
    logic  tbl_stale    [ROWS];

    // expected lines by line base
    line_t sb [addr_t];
    int    mismatch_errs;
    int    resp_errs;
    int    resp_count;

    cacheline_adapter dut0 (.*);
    tb_burst_memory mem0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // every dfp_resp pulse over the whole run
    always @(negedge clk) begin
        if (!rst && dfp_resp) begin
            resp_count++;
        end
    end

    function automatic addr_t line_base(input addr_t a);
        return a & ~addr_t'(`LINE_BITS / 8 - 1);
    endfunction

    // beat at byte address b holds b over its inverse
    function automatic line_t expected_line(input addr_t base);
        line_t l;
        addr_t b;
        if (sb.exists(base)) begin
            return sb[base];
        end
        for (int k = 0; k < `BEATS_PER_LINE; k++) begin
            b = base + addr_t'(k * `BEAT_BITS / 8);
            l[k * `BEAT_BITS +: `BEAT_BITS] = {b, ~b};
        end
        return l;
    endfunction

    task automatic set_row(input int i, input logic wr, input addr_t a, input line_t d,
                           input logic st, input logic stl);
        tbl_is_write[i] = wr;
        tbl_addr[i]     = a;
        tbl_wdata[i]    = d;
        tbl_stall[i]    = st;
        tbl_stale[i]    = stl;
    endtask

    task automatic report_mismatch(input string msg);
        mismatch_errs++;
        $display("MISMATCH @%0t state=%s %s", $time, dut0.seq0.state_q.name(), msg);
    endtask

    // no response may show up between requests
    task automatic idle_gap(input int n);
        repeat (n) begin
            @(negedge clk);
            if (dfp_resp) begin
                resp_errs++;
                $display("at %0t a response pulse appeared with no request held", $time);
            end
        end
    endtask

    task automatic run_row(input int i);
        addr_t base;
        int    rd_before;
        int    wr_before;
        base = line_base(tbl_addr[i]);
        // memory controls settle away from its falling-edge process
        @(posedge clk);
        stall_en = tbl_stall[i];
        stale_en = tbl_stale[i];
        @(negedge clk);
        rd_before = mem0.rd_cmd_n;
        wr_before = mem0.wr_log_n;
        dfp_addr  = tbl_addr[i];
        dfp_wdata = tbl_wdata[i];
        dfp_read  = !tbl_is_write[i];
        dfp_write = tbl_is_write[i];
        do @(negedge clk); while (!dfp_resp);
        if (!tbl_is_write[i]) begin
            if (mem0.rd_cmd_n - rd_before != 1 || mem0.rd_cmd_addr !== base) begin
                report_mismatch($sformatf("row %0d read cmds %0d at %h, expected 1 at %h",
                                i, mem0.rd_cmd_n - rd_before, mem0.rd_cmd_addr, base));
            end
            if (dfp_rdata !== expected_line(base)) begin
                report_mismatch($sformatf("row %0d dfp_rdata %h expected %h",
                                i, dfp_rdata, expected_line(base)));
            end
            if (mem0.wr_log_n != wr_before) begin
                report_mismatch($sformatf("row %0d read produced write beats", i));
            end
        end else begin
            if (mem0.wr_log_n - wr_before != `BEATS_PER_LINE || mem0.rd_cmd_n != rd_before) begin
                report_mismatch($sformatf("row %0d write beats %0d read cmds %0d",
                                i, mem0.wr_log_n - wr_before, mem0.rd_cmd_n - rd_before));
            end else begin
                // quarters go out low to high, all at the line base
                for (int k = 0; k < `BEATS_PER_LINE; k++) begin
                    if (mem0.wr_log_addr[wr_before + k] !== base ||
                        mem0.wr_log_data[wr_before + k] !==
                        tbl_wdata[i][k * `BEAT_BITS +: `BEAT_BITS]) begin
                        report_mismatch($sformatf("row %0d beat %0d got %h at %h", i, k,
                                        mem0.wr_log_data[wr_before + k],
                                        mem0.wr_log_addr[wr_before + k]));
                    end
                end
            end
            sb[base] = tbl_wdata[i];
        end
        // cache drops the request one cycle after the response
        @(negedge clk);
        dfp_read  = 1'b0;
        dfp_write = 1'b0;
        if (dfp_resp) begin
            resp_errs++;
            $display("at %0t row %0d response pulse lasted more than one cycle", $time, i);
        end
    endtask

    initial begin
        rst           = 1'b1;
        dfp_addr      = '0;
        dfp_read      = 1'b0;
        dfp_write     = 1'b0;
        dfp_wdata     = '0;
        stall_en      = 1'b0;
        stale_en      = 1'b0;
        mismatch_errs = 0;
        resp_errs     = 0;
        resp_count    = 0;
        // op, address, wdata, stalls, stale beat
        set_row(0,  1'b0, 32'h0000_1000, '0,      1'b0, 1'b0);
        set_row(1,  1'b0, 32'h0000_1234, '0,      1'b0, 1'b0);
        set_row(2,  1'b1, 32'h0000_2008, WDATA_A, 1'b0, 1'b0);
        set_row(3,  1'b0, 32'h0000_2010, '0,      1'b0, 1'b0);
        set_row(4,  1'b1, 32'h0000_3000, WDATA_B, 1'b1, 1'b0);
        set_row(5,  1'b0, 32'h0000_3000, '0,      1'b1, 1'b0);
        set_row(6,  1'b0, 32'h0000_1040, '0,      1'b1, 1'b0);
        set_row(7,  1'b0, 32'h0000_2000, '0,      1'b0, 1'b1);
        set_row(8,  1'b0, 32'h0000_4000, '0,      1'b1, 1'b1);
        set_row(9,  1'b1, 32'h0000_2000, WDATA_C, 1'b1, 1'b0);
        set_row(10, 1'b0, 32'h0000_201f, '0,      1'b1, 1'b1);
        set_row(11, 1'b0, 32'h0000_5000, '0,      1'b0, 1'b1);
        repeat (2) @(negedge clk);
        rst = 1'b0;
        // outputs straight out of reset
        if (dfp_resp !== 1'b0 || bmem_read !== 1'b0 || bmem_write !== 1'b0 ||
            bmem_wdata !== '0) begin
            report_mismatch("outputs not idle after reset");
        end
        for (int i = 0; i < ROWS; i++) begin
            run_row(i);
            idle_gap(3);
        end
        // one pulse per request over the whole run
        if (resp_count != ROWS) begin
            resp_errs++;
            $display("saw %0d response pulses for %0d requests", resp_count, ROWS);
        end
        $display("rows %0d responses %0d mismatches %0d response errors %0d hold errors %0d",
                 ROWS, resp_count, mismatch_errs, resp_errs, mem0.hold_errs);
        if (mismatch_errs + resp_errs + mem0.hold_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // limit scales with the table length
    initial begin
        repeat (ROWS * 60 + 50) @(posedge clk);
        $display("watchdog expired, a request got no response in time");
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+source
source/line_adapter_pkg.sv
source/dfp_request_latch.sv
source/burst_sequencer.sv
source/deserializer.sv
source/cacheline_adapter.sv
testbench/tb_burst_memory.sv
testbench/tb_cacheline_adapter.sv
